// ==== common/shaPkg.sv ====
`default_nettype none

package shaPkg;

	typedef logic [31:0] wordT; // One SHA-256 word.

	// Working variables of the compression, a is the most significant word.
	typedef struct packed {
		wordT a;
		wordT b;
		wordT c;
		wordT d;
		wordT e;
		wordT f;
		wordT g;
		wordT h;
	} hashStateT;

	// Round constants, one per round.
	localparam wordT shaK [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Hash value before the first chunk of any message.
	localparam hashStateT shaH0 = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	function automatic wordT rotr(input wordT x, input int unsigned n);
		return (x >> n) | (x << (32 - n)); // Rotate right by n bits.
	endfunction

	// One compression round, kw is the round constant already added to the schedule word.
	function automatic hashStateT shaRound(input hashStateT s, input wordT kw);
		wordT sum0;
		wordT sum1;
		wordT t1;
		wordT t2;
		hashStateT rolled;
		sum1 = rotr(s.e, 6) ^ rotr(s.e, 11) ^ rotr(s.e, 25);
		sum0 = rotr(s.a, 2) ^ rotr(s.a, 13) ^ rotr(s.a, 22);
		t1 = s.h + sum1 + ((s.e & s.f) ^ (~s.e & s.g)) + kw; // Choice of f or g by e.
		t2 = sum0 + ((s.a & s.b) ^ (s.a & s.c) ^ (s.b & s.c)); // Majority of a, b and c.
		rolled = '{t1 + t2, s.a, s.b, s.c, s.d + t1, s.e, s.f, s.g};
		return rolled;
	endfunction

	// Next schedule word W[t+16] from W[t], W[t+1], W[t+9] and W[t+14].
	function automatic wordT shaSchedule(input wordT w0, input wordT w1,
			input wordT w9, input wordT w14);
		wordT sig0;
		wordT sig1;
		sig0 = rotr(w1, 7) ^ rotr(w1, 18) ^ (w1 >> 3);
		sig1 = rotr(w14, 17) ^ rotr(w14, 19) ^ (w14 >> 10);
		return sig1 + w9 + sig0 + w0;
	endfunction

endpackage

`default_nettype wire

// ==== common/minerPkg.sv ====
`default_nettype none

package minerPkg;

	localparam int JOB_WORDS = 12; // Addressable words in the block store.
	localparam int DIFF_WORD = 11; // Address of the difficulty; the words below it form the job.
	localparam int MAX_DIFFICULTY = 32; // Only the top word of the hash is ever tested.

	typedef logic [5:0] diffT; // Count of leading zero bits, 0 to 32.

	// Broadcast job. The midstate sits in words 0 to 7, the message words in 8 to 10.
	typedef struct packed {
		shaPkg::hashStateT midstate;
		shaPkg::wordT [0:2] message; // Message words that come before the nonce.
	} jobT;

	// True when the leading difficulty bits of the hash are all zero.
	function automatic logic meetsDifficulty(input logic [255:0] hash, input diffT difficulty);
		logic pass;
		pass = 1'b1;
		for (int i = 0; i < MAX_DIFFICULTY; i++) begin
			if (i < difficulty && hash[255 - i]) begin
				pass = 1'b0; // A one inside the required zero run fails the nonce.
			end
		end
		return pass;
	endfunction

endpackage

`default_nettype wire

// ==== source/blockStore.sv ====
`default_nettype none

module blockStore (
	input wire clk,
	input wire rst_i,
	input wire jobWe_i,
	input wire [3:0] jobAddr_i,
	input wire shaPkg::wordT jobData_i,
	input wire jobStart_i,
	output logic newJob_o,
	output minerPkg::jobT job_o,
	output minerPkg::diffT difficulty_o
);
	import shaPkg::*;
	import minerPkg::*;

	wordT jobWords [JOB_WORDS]; // Host-side copy, free to change during a scan.
	logic [$bits(jobT) - 1:0] jobFlat; // The job words in broadcast order.
	wordT diffWord;

	// Host writes. Addresses past the last job word are ignored.
	always_ff @(posedge clk) begin
		if (jobWe_i && jobAddr_i < JOB_WORDS) begin
			jobWords[jobAddr_i] <= jobData_i;
		end
	end

	// Word 0 lands in the most significant slot, so it becomes midstate word a.
	always_comb begin
		jobFlat = '0;
		for (int i = 0; i < DIFF_WORD; i++) begin
			jobFlat[$bits(jobT) - 1 - 32 * i -: 32] = jobWords[i];
		end
	end

	assign diffWord = jobWords[DIFF_WORD];

	// The broadcast copy only moves on a start, so the host can stage the next job early.
	always_ff @(posedge clk) begin
		if (jobStart_i) begin
			job_o <= jobT'(jobFlat);
			if (diffWord > MAX_DIFFICULTY) begin
				difficulty_o <= diffT'(MAX_DIFFICULTY); // Anything larger would be unreachable.
			end else begin
				difficulty_o <= diffT'(diffWord);
			end
		end
	end

	// One-cycle job strobe, one cycle behind the start.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			newJob_o <= 1'b0;
		end else begin
			newJob_o <= jobStart_i;
		end
	end

endmodule

`default_nettype wire

// ==== lattice/shaCore.sv ====
`default_nettype none

module shaCore (
	input wire clk,
	input wire rst_i,
	input wire start_i,
	input wire shaPkg::hashStateT midstate_i,
	input wire shaPkg::wordT [0:15] chunk_i,
	output logic done_o,
	output logic [255:0] hash_o
);
	import shaPkg::*;

	hashStateT work; // Working variables a to h.
	hashStateT midReg; // Midstate kept for the final addition.
	wordT [0:15] window; // Rolling schedule, window[0] is this round's word.
	logic [5:0] roundCnt;
	logic busy; // High for the 64 round cycles.
	logic finish; // High for the one cycle that adds the midstate back.
	wordT nextWord;

	assign nextWord = shaSchedule(window[0], window[1], window[9], window[14]);

	// Control. The start edge loads, 64 edges run rounds, and the next edge
	// raises done, which gives 65 cycles from start to done.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy <= 1'b0;
			finish <= 1'b0;
			roundCnt <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= finish & ~start_i; // A restart discards the result in flight.
			if (start_i) begin
				busy <= 1'b1; // A start during a run simply begins again.
				finish <= 1'b0;
				roundCnt <= '0;
			end else if (busy) begin
				roundCnt <= roundCnt + 6'd1;
				if (roundCnt == 6'd63) begin
					busy <= 1'b0;
					finish <= 1'b1;
				end
			end else begin
				finish <= 1'b0;
			end
		end
	end

	// Datapath.
	always_ff @(posedge clk) begin
		if (start_i) begin
			work <= midstate_i;
			midReg <= midstate_i;
			window <= chunk_i;
		end else if (busy) begin
			work <= shaRound(work, shaK[roundCnt] + window[0]);
			window <= {window[1:15], nextWord}; // Shift the schedule by one word.
		end else if (finish) begin
			// Feed-forward of the chaining value.
			hash_o <= {work.a + midReg.a, work.b + midReg.b,
				work.c + midReg.c, work.d + midReg.d,
				work.e + midReg.e, work.f + midReg.f,
				work.g + midReg.g, work.h + midReg.h};
		end
	end

endmodule

`default_nettype wire

// ==== lattice/latticeBlock.sv ====
`default_nettype none

module latticeBlock #(
	parameter int INDEX = 0,
	parameter int NUM_CORES = 4,
	parameter int SPAN_BITS = 5
) (
	input wire clk,
	input wire rst_i,
	input wire newJob_i,
	input wire minerPkg::jobT job_i,
	input wire minerPkg::diffT difficulty_i,
	output logic newJob_o,
	output minerPkg::jobT job_o,
	output minerPkg::diffT difficulty_o,
	input wire ack_i,
	output logic found_o,
	output shaPkg::wordT foundNonce_o,
	output logic spanDone_o
);
	import shaPkg::*;
	import minerPkg::*;

	localparam int LOG2_NUM_CORES = $clog2(NUM_CORES);

	typedef enum logic [1:0] {stIdle, stIssue, stWait, stHold} coreStateT;

	coreStateT state;
	logic [SPAN_BITS - 1:0] counter; // Low bits of the nonce under test.
	wordT nonce;
	wordT [0:15] chunk;
	logic shaStart;
	logic shaDone;
	logic [255:0] shaHash;
	logic hit; // The finished hash meets the difficulty.
	logic advance; // Move on to the next nonce.
	logic lastNonce;

	// Stage register of the job chain. The registered copy is also this core's working job,
	// since it only changes together with a new job strobe.
	always_ff @(posedge clk) begin
		job_o <= job_i;
		difficulty_o <= difficulty_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			newJob_o <= 1'b0;
		end else begin
			newJob_o <= newJob_i;
		end
	end

	// The core index fills the top bits, so the partitions never overlap.
	assign nonce = (wordT'(INDEX) << (32 - LOG2_NUM_CORES)) | wordT'(counter);
	assign foundNonce_o = nonce; // The counter is frozen while a find is held.

	// Final 64-byte chunk: three message words, the nonce, then the padding.
	always_comb begin
		chunk = '0;
		chunk[0:2] = job_o.message;
		chunk[3] = nonce;
		chunk[4] = 32'h8000_0000; // Terminating one bit.
		chunk[15] = 32'd640; // Message length of 80 bytes, in bits.
	end

	assign shaStart = (state == stIssue);
	assign hit = meetsDifficulty(shaHash, difficulty_o);
	assign lastNonce = &counter;
	assign advance = (state == stWait && shaDone && !hit) || (state == stHold && ack_i);

	shaCore sha (
		.clk,
		.rst_i,
		.start_i(shaStart),
		.midstate_i(job_o.midstate),
		.chunk_i(chunk),
		.done_o(shaDone),
		.hash_o(shaHash)
	);

	// Scan FSM. A done outside stWait belongs to an aborted job and is dropped.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= stIdle;
			counter <= '0;
			found_o <= 1'b0;
			spanDone_o <= 1'b0;
		end else if (newJob_i) begin
			state <= stIssue; // Abort whatever was running.
			counter <= '0;
			found_o <= 1'b0;
			spanDone_o <= 1'b0;
		end else if (state == stWait && shaDone && hit) begin
			found_o <= 1'b1; // Stall here until the buffer takes it.
			state <= stHold;
		end else if (advance) begin
			found_o <= 1'b0;
			if (lastNonce) begin
				spanDone_o <= 1'b1;
				state <= stIdle;
			end else begin
				counter <= counter + 1'b1;
				state <= stIssue;
			end
		end else if (state == stIssue) begin
			state <= stWait;
		end
	end

endmodule

`default_nettype wire

// ==== source/nonceBuffer.sv ====
`default_nettype none

module nonceBuffer #(
	parameter int NUM_CORES = 4,
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire rst_i,
	input wire newJob_i,
	input wire [NUM_CORES - 1:0] foundVec_i,
	input wire shaPkg::wordT [NUM_CORES - 1:0] foundNonces_i,
	output logic [NUM_CORES - 1:0] ackVec_o,
	input wire nonceRead_i,
	output logic nonceValid_o,
	output shaPkg::wordT nonce_o,
	output logic overflow_o
);
	import shaPkg::*;

	localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

	wordT fifoMem [FIFO_DEPTH];
	logic [PTR_BITS - 1:0] wrPtr;
	logic [PTR_BITS - 1:0] rdPtr;
	logic [COUNT_BITS - 1:0] count; // Entries held, 0 to FIFO_DEPTH.
	logic full;
	logic push;
	logic pop;
	wordT pushData;

	assign full = (count == COUNT_BITS'(FIFO_DEPTH));

	// Fixed priority. The lowest set bit is isolated, so core 0 wins ties.
	assign ackVec_o = full ? '0 : (foundVec_i & (~foundVec_i + NUM_CORES'(1)));
	assign push = |ackVec_o;
	assign pop = nonceRead_i && nonceValid_o;

	always_comb begin
		pushData = '0;
		for (int k = 0; k < NUM_CORES; k++) begin
			if (ackVec_o[k]) begin
				pushData = foundNonces_i[k]; // Grant is one-hot.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifoMem[wrPtr] <= pushData;
		end
	end

	// Pointers wrap at the depth, which need not be a power of two.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	assign nonceValid_o = (count != '0);
	assign nonce_o = fifoMem[rdPtr]; // Head entry, valid with nonceValid_o.

	// Sticky. Set when the FIFO is full and every core is stalled on a find.
	always_ff @(posedge clk) begin
		if (rst_i || newJob_i) begin
			overflow_o <= 1'b0;
		end else if (full && &foundVec_i) begin
			overflow_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/minerTop.sv ====
`default_nettype none

module minerTop #(
	parameter int NUM_CORES = 4,
	parameter int SPAN_BITS = 5,
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire rst_i,
	input wire jobWe_i,
	input wire [3:0] jobAddr_i,
	input wire shaPkg::wordT jobData_i,
	input wire jobStart_i,
	input wire nonceRead_i,
	output logic nonceValid_o,
	output shaPkg::wordT nonce_o,
	output logic overflow_o,
	output logic allDone_o
);
	import shaPkg::*;
	import minerPkg::*;

	// Job chain. Entry 0 comes from the store, entry k+1 leaves core k.
	logic chainNewJob [NUM_CORES + 1];
	jobT chainJob [NUM_CORES + 1];
	diffT chainDiff [NUM_CORES + 1];

	logic [NUM_CORES - 1:0] foundVec;
	logic [NUM_CORES - 1:0] ackVec;
	logic [NUM_CORES - 1:0] spanDone;
	wordT [NUM_CORES - 1:0] foundNonces;

	blockStore store (
		.clk,
		.rst_i,
		.jobWe_i,
		.jobAddr_i,
		.jobData_i,
		.jobStart_i,
		.newJob_o(chainNewJob[0]),
		.job_o(chainJob[0]),
		.difficulty_o(chainDiff[0])
	);

	for (genvar k = 0; k < NUM_CORES; k++) begin : gCore
		latticeBlock #(
			.INDEX(k),
			.NUM_CORES(NUM_CORES),
			.SPAN_BITS(SPAN_BITS)
		) core (
			.clk,
			.rst_i,
			.newJob_i(chainNewJob[k]),
			.job_i(chainJob[k]),
			.difficulty_i(chainDiff[k]),
			.newJob_o(chainNewJob[k + 1]),
			.job_o(chainJob[k + 1]),
			.difficulty_o(chainDiff[k + 1]),
			.ack_i(ackVec[k]),
			.found_o(foundVec[k]),
			.foundNonce_o(foundNonces[k]),
			.spanDone_o(spanDone[k])
		);
	end

	// The buffer sees the job strobe as it leaves the last core. By then every core
	// has dropped its old find, so overflow cannot set again from stale requests.
	nonceBuffer #(
		.NUM_CORES(NUM_CORES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) buffer (
		.clk,
		.rst_i,
		.newJob_i(chainNewJob[NUM_CORES]),
		.foundVec_i(foundVec),
		.foundNonces_i(foundNonces),
		.ackVec_o(ackVec),
		.nonceRead_i,
		.nonceValid_o,
		.nonce_o,
		.overflow_o
	);

	assign allDone_o = &spanDone; // Every partition has been scanned.

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
`default_nettype none

module clockGen #(
	parameter int HALF_PERIOD = 5 // Half of the 10-unit clock period.
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== test/shaModel.svh ====
`ifndef SHA_MODEL_SVH
`define SHA_MODEL_SVH

// Reference model of one miner hash, written out with a full 64-word schedule.

function automatic logic [31:0] modelRotr(input logic [31:0] x, input int n);
	logic [63:0] doubled;
	doubled = {x, x} >> n; // The low half now holds x rotated right by n.
	return doubled[31:0];
endfunction

// Compresses the final chunk for one nonce on the job's midstate.
// The job's top eight words are the midstate, the three below are message words.
function automatic logic [255:0] modelHash(input logic [351:0] job, input logic [31:0] nonce);
	logic [31:0] w [64];
	logic [31:0] v [8];
	logic [31:0] s0;
	logic [31:0] s1;
	logic [31:0] t1;
	logic [31:0] t2;
	logic [255:0] digest;
	for (int i = 0; i < 16; i++) begin
		w[i] = 32'd0;
	end
	w[0] = job[95:64];
	w[1] = job[63:32];
	w[2] = job[31:0];
	w[3] = nonce;
	w[4] = 32'h8000_0000; // The padding one bit follows the nonce.
	w[15] = 32'd640; // An 80-byte header is 640 bits long.
	for (int i = 16; i < 64; i++) begin
		s0 = modelRotr(w[i - 15], 7) ^ modelRotr(w[i - 15], 18) ^ (w[i - 15] >> 3);
		s1 = modelRotr(w[i - 2], 17) ^ modelRotr(w[i - 2], 19) ^ (w[i - 2] >> 10);
		w[i] = w[i - 16] + s0 + w[i - 7] + s1;
	end
	for (int j = 0; j < 8; j++) begin
		v[j] = job[351 - 32 * j -: 32];
	end
	for (int i = 0; i < 64; i++) begin
		s1 = modelRotr(v[4], 6) ^ modelRotr(v[4], 11) ^ modelRotr(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + shaPkg::shaK[i] + w[i];
		s0 = modelRotr(v[0], 2) ^ modelRotr(v[0], 13) ^ modelRotr(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int j = 7; j > 0; j--) begin
			v[j] = v[j - 1]; // Every word moves one place down.
		end
		v[4] = v[4] + t1; // v[4] holds the old d at this point.
		v[0] = t1 + t2;
	end
	for (int j = 0; j < 8; j++) begin
		digest[255 - 32 * j -: 32] = v[j] + job[351 - 32 * j -: 32];
	end
	return digest;
endfunction

// Number of zero bits at the top of a hash.
function automatic int modelZeros(input logic [255:0] hash);
	int n;
	n = 0;
	while (n < 256 && !hash[255 - n]) begin
		n++;
	end
	return n;
endfunction

`endif

// ==== test/minerTb.sv ====
`default_nettype none

module minerTb;
	import shaPkg::*;
	import minerPkg::*;

	localparam int NUM_CORES = 4;
	localparam int SPAN_BITS = 5;
	localparam int FIFO_DEPTH = 4;
	localparam int LOG2_CORES = $clog2(NUM_CORES);
	// Bits between the core index and the counter, always zero in a valid nonce.
	localparam logic [31:0] GAP_MASK =
		(32'hFFFF_FFFF >> LOG2_CORES) & ~((32'd1 << SPAN_BITS) - 32'd1);
	// Three full scans of about 67 cycles per nonce, plus a quarter on top.
	localparam int TIMEOUT_CYCLES = (3 * (1 << SPAN_BITS) * 67 * 5) / 4;

	`include "shaModel.svh"

	logic clk;
	logic rst;
	logic jobWe;
	logic [3:0] jobAddr;
	logic [31:0] jobData;
	logic jobStart;
	logic nonceRead = 1'b0;
	logic nonceValid;
	logic [31:0] nonce;
	logic overflow;
	logic allDone;

	logic [351:0] curJob; // Midstate and message words of the job last started.
	logic [5:0] curDiff;
	logic [31:0] popped [$]; // Nonces read back while collection is on.
	logic [31:0] expectQ [$]; // Model's succeeding nonces, ascending.
	logic [31:0] lastPerCore [NUM_CORES];
	logic hasLast [NUM_CORES];
	logic popNow;
	logic [LOG2_CORES - 1:0] popCore;
	logic quietCheck = 1'b0;
	logic modelCheck = 1'b0; // Also turns on collection of popped nonces.
	logic noOverflowCheck = 1'b0;
	logic holdCheck = 1'b0;
	logic heldCheck = 1'b0;
	logic readEnable = 1'b0;
	int popIndex = 0;
	int cycleCount = 0;
	int checkTest = 2; // Test charged with model and partition errors.
	int orderTest = 3; // Test charged with order and overflow errors.
	int errors [1:5] = '{default: 0};
	int errorTotal = 0;
	int passCount = 0;
	int failCount = 0;

	clockGen clocks (.clk_o(clk));

	minerTop #(
		.NUM_CORES(NUM_CORES),
		.SPAN_BITS(SPAN_BITS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) UUT (
		.clk(clk),
		.rst_i(rst),
		.jobWe_i(jobWe),
		.jobAddr_i(jobAddr),
		.jobData_i(jobData),
		.jobStart_i(jobStart),
		.nonceRead_i(nonceRead),
		.nonceValid_o(nonceValid),
		.nonce_o(nonce),
		.overflow_o(overflow),
		.allDone_o(allDone)
	);

	assign popNow = nonceRead && nonceValid; // The FIFO pops on this edge.
	assign popCore = nonce[31 -: LOG2_CORES];

	task automatic flagMismatch(input int testNo, input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("[ERROR] %0t: %s is 0x%h, expected 0x%h", $time, name, got, want);
		errors[testNo]++;
		errorTotal++;
	endtask

	task automatic finishTest(input int testNo, input string name);
		if (errors[testNo] == 0) begin
			passCount++;
			$display("Test %0d, %s: passed", testNo, name);
		end else begin
			failCount++;
			$display("Test %0d, %s: failed with %0d errors", testNo, name, errors[testNo]);
		end
	endtask

	// Writes eleven random job words and the difficulty, then pulses the start.
	task automatic loadJob(input logic [5:0] diff);
		logic [31:0] word;
		for (int i = 0; i < 12; i++) begin
			word = (i == 11) ? 32'(diff) : $urandom();
			@(posedge clk);
			jobWe <= 1'b1;
			jobAddr <= 4'(i);
			jobData <= word;
			if (i < 11) begin
				curJob[351 - 32 * i -: 32] = word;
			end
		end
		@(posedge clk);
		jobWe <= 1'b0;
		jobStart <= 1'b1;
		quietCheck <= 1'b0; // Outputs may move once a job is running.
		curDiff = diff;
		for (int k = 0; k < NUM_CORES; k++) begin
			hasLast[k] <= 1'b0;
		end
		@(posedge clk);
		jobStart <= 1'b0;
	endtask

	// Every nonce of every partition through the model.
	task automatic buildExpected();
		logic [31:0] n;
		expectQ.delete();
		for (int k = 0; k < NUM_CORES; k++) begin
			for (int c = 0; c < (1 << SPAN_BITS); c++) begin
				n = (32'(k) << (32 - LOG2_CORES)) | 32'(c);
				if (modelZeros(modelHash(curJob, n)) >= curDiff) begin
					expectQ.push_back(n);
				end
			end
		end
	endtask

	task automatic compareSets(input int testNo);
		popped.sort();
		assert (popped.size() == expectQ.size())
			else flagMismatch(testNo, "popped nonce count", popped.size(), expectQ.size());
		for (int i = 0; i < popped.size() && i < expectQ.size(); i++) begin
			assert (popped[i] == expectQ[i])
				else flagMismatch(testNo, $sformatf("popped nonce %0d", i), popped[i], expectQ[i]);
		end
	endtask

	// Host reader. A read is raised for one cycle at a time, so each pop is seen once.
	always @(posedge clk) begin
		if (rst) begin
			nonceRead <= 1'b0;
		end else begin
			if (popNow) begin
				popIndex <= popIndex + 1;
				if (modelCheck) begin
					popped.push_back(nonce);
					lastPerCore[popCore] <= nonce;
					hasLast[popCore] <= 1'b1;
				end
			end
			nonceRead <= readEnable && nonceValid && !nonceRead;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	quietAfterReset: assert property (@(posedge clk) disable iff (rst)
		quietCheck |-> !(nonceValid || overflow || allDone))
		else flagMismatch(1, "{nonceValid_o, overflow_o, allDone_o}",
			$sampled({nonceValid, overflow, allDone}), 32'd0);

	popMeetsModel: assert property (@(posedge clk) disable iff (rst)
		(modelCheck && popNow) |-> (modelZeros(modelHash(curJob, nonce)) >= curDiff))
		else flagMismatch(checkTest, "leading zeros of hash(nonce_o), at least",
			modelZeros(modelHash($sampled(curJob), $sampled(nonce))), $sampled(curDiff));

	popInPartition: assert property (@(posedge clk) disable iff (rst)
		(modelCheck && popNow) |-> ((nonce & GAP_MASK) == 32'd0))
		else flagMismatch(checkTest, "nonce_o bits between core and counter",
			$sampled(nonce) & GAP_MASK, 32'd0);

	popAscending: assert property (@(posedge clk) disable iff (rst)
		(modelCheck && popNow && hasLast[popCore]) |-> (nonce > lastPerCore[popCore]))
		else flagMismatch(orderTest, "nonce_o, above the previous nonce of its core",
			$sampled(nonce), $sampled(lastPerCore[popCore]));

	noOverflow: assert property (@(posedge clk) disable iff (rst)
		noOverflowCheck |-> !overflow)
		else flagMismatch(orderTest, "overflow_o", $sampled(overflow), 32'd0);

	validHeld: assert property (@(posedge clk) disable iff (rst)
		holdCheck |-> nonceValid)
		else flagMismatch(4, "nonceValid_o", $sampled(nonceValid), 32'd1);

	// With difficulty 0 the first find of each core arrives in index order.
	heldEntries: assert property (@(posedge clk) disable iff (rst)
		(heldCheck && popNow && popIndex < FIFO_DEPTH) |->
			(nonce == (32'(popIndex) << (32 - LOG2_CORES))))
		else flagMismatch(4, "nonce_o", $sampled(nonce),
			32'($sampled(popIndex)) << (32 - LOG2_CORES));

	initial begin
		void'($urandom(86));
		rst = 1'b1;
		jobWe = 1'b0;
		jobAddr = 4'd0;
		jobData = 32'd0;
		jobStart = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		quietCheck <= 1'b1;
		repeat (8) @(posedge clk);

		loadJob(6'd4); // Job A. The quiet check ends at its start.
		finishTest(1, "outputs low after reset");
		buildExpected();
		popped.delete();
		modelCheck <= 1'b1;
		noOverflowCheck <= 1'b1;
		readEnable <= 1'b1;
		while (!allDone) @(posedge clk);
		while (nonceValid || nonceRead) @(posedge clk); // Drain what is left.
		repeat (2) @(posedge clk);
		compareSets(3);
		modelCheck <= 1'b0;
		noOverflowCheck <= 1'b0;
		readEnable <= 1'b0;
		finishTest(2, "popped nonces meet difficulty 4");
		finishTest(3, "full set in order, all done, no overflow");

		popIndex <= 0;
		loadJob(6'd0); // Job B, every nonce succeeds.
		while (!nonceValid) @(posedge clk);
		holdCheck <= 1'b1;
		while (!overflow) @(posedge clk);
		holdCheck <= 1'b0;
		heldCheck <= 1'b1;
		readEnable <= 1'b1;
		while (popIndex < FIFO_DEPTH) @(posedge clk);
		readEnable <= 1'b0;
		heldCheck <= 1'b0;
		finishTest(4, "FIFO fills and overflow sets");

		checkTest = 5;
		orderTest = 5;
		loadJob(6'd4); // Job C aborts job B mid-scan.
		repeat (NUM_CORES + 2) @(posedge clk); // The strobe crosses the chain.
		noOverflowCheck <= 1'b1;
		readEnable <= 1'b1;
		while (nonceValid || nonceRead) @(posedge clk); // Old job B entries leave first.
		popped.delete();
		buildExpected();
		modelCheck <= 1'b1;
		while (!allDone) @(posedge clk);
		while (nonceValid || nonceRead) @(posedge clk);
		repeat (2) @(posedge clk);
		compareSets(5);
		modelCheck <= 1'b0;
		noOverflowCheck <= 1'b0;
		readEnable <= 1'b0;
		finishTest(5, "new job clears overflow and scans anew");

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0 && errorTotal == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+test
common/shaPkg.sv
common/minerPkg.sv
source/blockStore.sv
lattice/shaCore.sv
lattice/latticeBlock.sv
source/nonceBuffer.sv
source/minerTop.sv
test/clockGen.sv
test/minerTb.sv
